//--- files.f
+incdir+testbench
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decoder.sv
hw/hazard_unit.sv
hw/alu_stage.sv
hw/mul_pipe.sv
hw/wb_arbiter.sv
hw/reg_bank.sv
hw/cpu_top.sv
testbench/tb_cpu.sv

//--- Makefile
SIM      = verilator
SIMFLAGS = --binary --timing -Wno-fatal
TOP      = tb_cpu
FILELIST = files.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = all tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ==============================
// Instruction encoders
// ==============================
localparam logic [6:0] ISA_OP_REG = 7'b0110011;
localparam logic [6:0] ISA_OP_IMM = 7'b0010011;
localparam logic [6:0] ISA_BRANCH = 7'b1100011;

function automatic word_t enc_r(input int f7, input int f3, input int rd, input int rs1,
                                input int rs2);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], ISA_OP_REG};
endfunction

function automatic word_t enc_b(input int f3, input int rs1, input int rs2, input int off);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], ISA_BRANCH};
endfunction

function automatic word_t enc_add(input int rd, input int rs1, input int rs2);
  return enc_r(0, 0, rd, rs1, rs2);
endfunction

function automatic word_t enc_sub(input int rd, input int rs1, input int rs2);
  return enc_r(32, 0, rd, rs1, rs2);
endfunction

function automatic word_t enc_xor(input int rd, input int rs1, input int rs2);
  return enc_r(0, 4, rd, rs1, rs2);
endfunction

function automatic word_t enc_or(input int rd, input int rs1, input int rs2);
  return enc_r(0, 6, rd, rs1, rs2);
endfunction

function automatic word_t enc_and(input int rd, input int rs1, input int rs2);
  return enc_r(0, 7, rd, rs1, rs2);
endfunction

function automatic word_t enc_mul(input int rd, input int rs1, input int rs2);
  return enc_r(1, 0, rd, rs1, rs2);
endfunction

function automatic word_t enc_addi(input int rd, input int rs1, input int imm);
  return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], ISA_OP_IMM};
endfunction

function automatic word_t enc_beq(input int rs1, input int rs2, input int off);
  return enc_b(0, rs1, rs2, off);
endfunction

function automatic word_t enc_bne(input int rs1, input int rs2, input int off);
  return enc_b(1, rs1, rs2, off);
endfunction

// ==============================
// ISA reference model
// ==============================
// Walks the ROM in program order and lists every register write
function automatic void run_model();
  word_t    regs [32];
  word_t    instr;
  word_t    a;
  word_t    b;
  word_t    res;
  addr_t    pc;
  addr_t    next_pc;
  logic     writes;
  reg_idx_t rd;
  int       steps;
  for (int i = 0; i < 32; i++) begin
    regs[i] = '0;
  end
  exp_count = 0;
  pc = RESET_PC;
  steps = 0;
  while (pc < addr_t'(prog_len * 4) && steps < 1000) begin
    instr   = rom[pc[7:2]];
    rd      = instr[11:7];
    a       = regs[instr[19:15]];
    b       = regs[instr[24:20]];
    res     = '0;
    writes  = 1'b1;
    next_pc = pc + 32'd4;
    case (instr[6:0])
      ISA_OP_REG: begin
        case ({instr[31:25], instr[14:12]})
          10'b0000000_000: res = a + b;
          10'b0100000_000: res = a - b;
          10'b0000000_100: res = a ^ b;
          10'b0000000_110: res = a | b;
          10'b0000000_111: res = a & b;
          10'b0000001_000: res = a * b;
          default:         writes = 1'b0;
        endcase
      end
      ISA_OP_IMM: res = a + {{20{instr[31]}}, instr[31:20]};
      ISA_BRANCH: begin
        writes = 1'b0;
        if ((instr[14:12] == 3'b000 && a == b) || (instr[14:12] == 3'b001 && a != b)) begin
          next_pc = pc + {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        end
      end
      default: writes = 1'b0;
    endcase
    if (writes && rd != 5'd0 && exp_count < EXP_MAX) begin
      regs[rd] = res;
      exp_list[exp_count] = '{valid: 1'b1, rd: rd, data: res};
      exp_count++;
    end
    pc = next_pc;
    steps++;
  end
endfunction

// 32-bit xorshift, shifts 13/17/5
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] s;
  s = x ^ (x << 13);
  s = s ^ (s >> 17);
  s = s ^ (s << 5);
  return s;
endfunction

`endif

//--- testbench/tb_cpu.sv
`default_nettype none

module tb_cpu;
  import core_pkg::*;

  localparam int MUL_STAGES   = MUL_STAGES_DEFAULT;
  localparam int ROM_WORDS    = 64;
  localparam int EXP_MAX      = 64;
  localparam int RESET_CYCLES = 5;
  localparam int DRAIN_CYCLES = MUL_STAGES + 8;

  logic  clk;
  logic  rst;
  addr_t imem_addr;
  word_t imem_data;
  wb_t   commit;

  word_t rom [ROM_WORDS];
  int    prog_len = 0;
  wb_t   exp_list [EXP_MAX];
  logic  exp_used [EXP_MAX];
  int    exp_count = 0;

  int          err_count    = 0;
  int          tests_run    = 0;
  int          tests_failed = 0;
  int          cycle_count  = 0;
  int          cycle_limit  = 100;
  logic [31:0] rng_state;

  `include "tb_model.svh"

  cpu_top #(
    .MUL_STAGES (MUL_STAGES)
  ) dut_i (
    .clk_i       (clk),
    .rst_i       (rst),
    .imem_addr_o (imem_addr),
    .imem_data_i (imem_data),
    .commit_o    (commit)
  );

  // Past the program the core only sees NOPs
  assign imem_data = (imem_addr < addr_t'(prog_len * 4)) ? rom[imem_addr[7:2]] : NOP_INSTR;

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Budget grows as each test adds its program
  initial begin : watchdog
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run still going after %0d cycles, the core stopped committing",
             cycle_count);
    $display("tests failed");
    $finish;
  end

  // ==============================
  // Checks
  // ==============================
  task automatic compare_wb(input wb_t got, input wb_t exp, input string what);
    logic bad;
    bad = (got.valid !== exp.valid);
    if (exp.valid) begin
      bad = bad || (got.rd !== exp.rd) || (got.data !== exp.data);
    end
    if (bad) begin
      $display("FAIL %0t: %s got valid=%0b x%0d=%h, expected valid=%0b x%0d=%h", $time, what,
               got.valid, got.rd, got.data, exp.valid, exp.rd, exp.data);
      err_count++;
    end
  endtask

  task automatic compare_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t: %s got %h, expected %h", $time, what, got, exp);
      err_count++;
    end
  endtask

  // Oldest unmatched write to the same rd
  task automatic check_commit(input wb_t got);
    int idx;
    idx = -1;
    for (int i = 0; i < exp_count; i++) begin
      if (idx < 0 && !exp_used[i] && exp_list[i].rd == got.rd) begin
        idx = i;
      end
    end
    if (idx < 0) begin
      $display("Unexpected commit to x%0d with data %h at time %0t, nothing left to write it",
               got.rd, got.data, $time);
      err_count++;
    end else begin
      exp_used[idx] = 1'b1;
      compare_wb(got, exp_list[idx], $sformatf("commit %0d", idx));
    end
  endtask

  // ==============================
  // Test sequencing
  // ==============================
  task automatic begin_test();
    @(negedge clk);
    rst = 1'b0;
    prog_len = 0;
  endtask

  task automatic emit(input word_t instr);
    rom[prog_len] = instr;
    prog_len++;
  endtask

  task automatic run_program(input string name);
    int errs_before;
    int seen;
    errs_before = err_count;
    run_model();
    for (int i = 0; i < EXP_MAX; i++) begin
      exp_used[i] = 1'b0;
    end
    cycle_limit += prog_len * (MUL_STAGES + 6);
    repeat (RESET_CYCLES) @(negedge clk);
    compare_addr(imem_addr, RESET_PC, "PC in reset");
    compare_wb(commit, '0, "commit in reset");
    rst = 1'b1;
    seen = 0;
    while (seen < exp_count) begin
      @(negedge clk);
      if (commit.valid) begin
        check_commit(commit);
        seen++;
      end
    end
    // Anything still arriving is a flushed or duplicate write
    repeat (DRAIN_CYCLES) begin
      @(negedge clk);
      if (commit.valid) begin
        check_commit(commit);
      end
    end
    for (int i = 0; i < exp_count; i++) begin
      if (!exp_used[i]) begin
        $display("Missing commit: x%0d = %h never appeared", exp_list[i].rd, exp_list[i].data);
        err_count++;
      end
    end
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %-8s ok, %0d commits", name, exp_count);
    end else begin
      tests_failed++;
      $display("test %-8s had %0d errors", name, err_count - errs_before);
    end
  endtask

  // ==============================
  // Directed tests
  // ==============================
  task automatic test_alu_chain();
    begin_test();
    emit(enc_addi(1, 0, 100));
    emit(enc_addi(2, 1, -37));
    emit(enc_add(3, 1, 2));
    emit(enc_sub(4, 3, 1));
    emit(enc_and(5, 4, 3));
    emit(enc_or(6, 5, 2));
    emit(enc_xor(7, 6, 1));
    emit(enc_addi(7, 7, 5));
    emit(enc_sub(8, 0, 7));
    run_program("chain");
  endtask

  task automatic test_x0();
    begin_test();
    emit(enc_addi(1, 0, 7));
    emit(enc_addi(0, 0, 55));
    emit(enc_add(0, 1, 1));
    emit(enc_mul(0, 1, 1));
    emit(enc_addi(2, 0, 3));
    emit(enc_add(3, 0, 1));
    emit(enc_xor(4, 0, 0));
    run_program("x0");
  endtask

  task automatic test_branches();
    begin_test();
    emit(enc_addi(1, 0, 5));
    emit(enc_addi(2, 0, 5));
    emit(enc_beq(1, 2, 12));
    emit(enc_mul(3, 1, 2));
    emit(enc_addi(4, 0, 2));
    emit(enc_addi(5, 0, 3));
    emit(enc_bne(1, 5, 8));
    emit(enc_addi(6, 0, 9));
    emit(enc_beq(1, 5, 8));
    emit(enc_addi(7, 0, 4));
    emit(enc_bne(1, 2, 8));
    emit(enc_addi(8, 0, 6));
    run_program("branch");
  endtask

  // ALU ops right behind a MUL meet its result at writeback
  task automatic test_mul();
    begin_test();
    emit(enc_addi(1, 0, 7));
    emit(enc_addi(2, 0, -3));
    emit(enc_mul(3, 1, 2));
    emit(enc_mul(5, 2, 2));
    emit(enc_addi(7, 0, 1));
    emit(enc_addi(8, 0, 2));
    emit(enc_addi(9, 0, 3));
    emit(enc_add(4, 3, 1));
    emit(enc_add(13, 5, 1));
    emit(enc_mul(10, 4, 5));
    emit(enc_xor(11, 1, 2));
    emit(enc_or(12, 1, 2));
    emit(enc_add(6, 10, 4));
    run_program("mul");
  endtask

  task automatic test_random();
    int rd;
    int rs1;
    int rs2;
    begin_test();
    rng_state = 32'd43199;
    for (int i = 0; i < 40; i++) begin
      rng_state = xorshift32(rng_state);
      rd  = int'(rng_state[3:0]);
      rs1 = int'(rng_state[7:4]);
      rs2 = int'(rng_state[11:8]);
      case (rng_state[14:12])
        3'd0:    emit(enc_add(rd, rs1, rs2));
        3'd1:    emit(enc_sub(rd, rs1, rs2));
        3'd2:    emit(enc_and(rd, rs1, rs2));
        3'd3:    emit(enc_or(rd, rs1, rs2));
        3'd4:    emit(enc_xor(rd, rs1, rs2));
        3'd7:    emit(enc_mul(rd, rs1, rs2));
        default: emit(enc_addi(rd, rs1, int'(rng_state[31:20])));
      endcase
    end
    run_program("random");
  endtask

  initial begin
    rst = 1'b0;
    test_alu_chain();
    test_x0();
    test_branches();
    test_mul();
    test_random();
    $display("%0d tests run, %0d passed, %0d failed, %0d check errors",
             tests_run, tests_run - tests_failed, tests_failed, err_count);
    if (err_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/cpu_top.sv
`default_nettype none

module cpu_top #(
  parameter int MUL_STAGES = core_pkg::MUL_STAGES_DEFAULT
) (
  input  logic            clk_i,
  input  logic            rst_i,
  output core_pkg::addr_t imem_addr_o,
  input  core_pkg::word_t imem_data_i,
  output core_pkg::wb_t   commit_o
);
  import core_pkg::*;

  // Fetch to decode
  logic  dec_valid;
  addr_t dec_pc;
  word_t dec_instr;

  // Decode
  reg_idx_t     rs1_idx;
  reg_idx_t     rs2_idx;
  word_t        rs1_data;
  word_t        rs2_data;
  hazard_regs_t hazard_regs;
  alu_req_t     alu_req_d;
  mul_req_t     mul_req_d;
  mul_req_t     mul_entry;

  // Decode/ALU register
  logic     alu_valid_q;
  alu_req_t alu_pay_q;
  alu_req_t alu_req_q;

  // Execute, writeback and control
  wb_t                  alu_wb;
  wb_t                  mul_wb;
  wb_t [MUL_STAGES-1:0] mul_tags;
  logic                 branch_taken;
  addr_t                branch_target;
  logic                 alu_hold;
  logic                 stall;
  logic                 flush;

  // ==============================
  // Front end
  // ==============================
  fetch_unit fetch_unit_i (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .stall_i         (stall),
    .branch_taken_i  (branch_taken),
    .branch_target_i (branch_target),
    .imem_data_i     (imem_data_i),
    .imem_addr_o     (imem_addr_o),
    .dec_valid_o     (dec_valid),
    .dec_pc_o        (dec_pc),
    .dec_instr_o     (dec_instr)
  );

  decoder decoder_i (
    .valid_i    (dec_valid),
    .pc_i       (dec_pc),
    .instr_i    (dec_instr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_idx_o  (rs1_idx),
    .rs2_idx_o  (rs2_idx),
    .hazard_o   (hazard_regs),
    .alu_req_o  (alu_req_d),
    .mul_req_o  (mul_req_d)
  );

  hazard_unit #(
    .MUL_STAGES (MUL_STAGES)
  ) hazard_unit_i (
    .hazard_i       (hazard_regs),
    .dec_valid_i    (dec_valid),
    .alu_busy_i     (alu_wb),
    .mul_tags_i     (mul_tags),
    .wb_busy_i      (commit_o),
    .branch_taken_i (branch_taken),
    .alu_hold_i     (alu_hold),
    .stall_o        (stall),
    .flush_o        (flush)
  );

  reg_bank reg_bank_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .rd_a_i   (rs1_idx),
    .rd_b_i   (rs2_idx),
    .wr_i     (commit_o),
    .data_a_o (rs1_data),
    .data_b_o (rs2_data)
  );

  // ==============================
  // Decode/ALU register
  // ==============================
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      alu_valid_q <= 1'b0;
    end else if (flush) begin
      alu_valid_q <= 1'b0;
    end else if (!alu_hold) begin
      alu_valid_q <= alu_req_d.valid && !stall;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!alu_hold) begin
      alu_pay_q <= alu_req_d;
    end
  end

  always_comb begin
    alu_req_q       = alu_pay_q;
    alu_req_q.valid = alu_valid_q;
  end

  // Same bubble rule at the multiply entry
  always_comb begin
    mul_entry       = mul_req_d;
    mul_entry.valid = mul_req_d.valid && !stall && !flush;
  end

  // ==============================
  // Execute and writeback
  // ==============================
  alu_stage alu_stage_i (
    .req_i           (alu_req_q),
    .wb_o            (alu_wb),
    .branch_taken_o  (branch_taken),
    .branch_target_o (branch_target)
  );

  mul_pipe #(
    .MUL_STAGES (MUL_STAGES)
  ) mul_pipe_i (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .req_i  (mul_entry),
    .tags_o (mul_tags),
    .wb_o   (mul_wb)
  );

  wb_arbiter wb_arbiter_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .alu_wb_i   (alu_wb),
    .mul_wb_i   (mul_wb),
    .alu_hold_o (alu_hold),
    .commit_o   (commit_o)
  );

endmodule

`default_nettype wire

//--- hw/reg_bank.sv
`default_nettype none

module reg_bank (
  input  logic               clk_i,
  input  logic               rst_i,
  input  core_pkg::reg_idx_t rd_a_i,
  input  core_pkg::reg_idx_t rd_b_i,
  input  core_pkg::wb_t      wr_i,
  output core_pkg::word_t    data_a_o,
  output core_pkg::word_t    data_b_o
);
  import core_pkg::*;

  // x0 has no storage
  word_t regs_q [1:31];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.valid && wr_i.rd != '0) begin
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  function automatic word_t read_port(input reg_idx_t idx);
    word_t value;
    if (idx == '0) begin
      value = '0;
    end else if (wr_i.valid && wr_i.rd == idx) begin
      // Write-through of this cycle's commit
      value = wr_i.data;
    end else begin
      value = regs_q[idx];
    end
    return value;
  endfunction

  always_comb begin
    data_a_o = read_port(rd_a_i);
    data_b_o = read_port(rd_b_i);
  end

endmodule

`default_nettype wire

//--- hw/wb_arbiter.sv
`default_nettype none

module wb_arbiter (
  input  logic          clk_i,
  input  logic          rst_i,
  input  core_pkg::wb_t alu_wb_i,
  input  core_pkg::wb_t mul_wb_i,
  output logic          alu_hold_o,
  output core_pkg::wb_t commit_o
);
  import core_pkg::*;

  wb_src_e  src;
  wb_t      winner;
  logic     valid_q;
  reg_idx_t rd_q;
  word_t    data_q;

  // Multiply cannot stall, so it always wins
  assign src        = mul_wb_i.valid ? WB_SRC_MUL : WB_SRC_ALU;
  assign winner     = (src == WB_SRC_MUL) ? mul_wb_i : alu_wb_i;
  assign alu_hold_o = alu_wb_i.valid && mul_wb_i.valid;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= winner.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q   <= winner.rd;
    data_q <= winner.data;
  end

  assign commit_o = '{valid: valid_q, rd: rd_q, data: data_q};

endmodule

`default_nettype wire

//--- hw/mul_pipe.sv
`default_nettype none

module mul_pipe #(
  parameter int MUL_STAGES = core_pkg::MUL_STAGES_DEFAULT
) (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  core_pkg::mul_req_t             req_i,
  output core_pkg::wb_t [MUL_STAGES-1:0] tags_o,
  output core_pkg::wb_t                  wb_o
);
  import core_pkg::*;

  logic [MUL_STAGES-1:0] valid_q;
  reg_idx_t              rd_q   [MUL_STAGES];
  word_t                 data_q [MUL_STAGES];
  word_t                 product;

  // Low half of the product only
  assign product = req_i.a * req_i.b;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= req_i.valid;
      for (int i = 1; i < MUL_STAGES; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    rd_q[0]   <= req_i.rd;
    data_q[0] <= product;
    for (int i = 1; i < MUL_STAGES; i++) begin
      rd_q[i]   <= rd_q[i-1];
      data_q[i] <= data_q[i-1];
    end
  end

  always_comb begin
    for (int i = 0; i < MUL_STAGES; i++) begin
      tags_o[i] = '{valid: valid_q[i], rd: rd_q[i], data: data_q[i]};
    end
  end

  assign wb_o = tags_o[MUL_STAGES-1];

endmodule

`default_nettype wire

//--- hw/alu_stage.sv
`default_nettype none

module alu_stage (
  input  core_pkg::alu_req_t req_i,
  output core_pkg::wb_t      wb_o,
  output logic               branch_taken_o,
  output core_pkg::addr_t    branch_target_o
);
  import core_pkg::*;

  word_t result;
  logic  cond;

  always_comb begin
    result = '0;
    cond   = 1'b0;
    case (req_i.op)
      ALU_ADD: result = req_i.a + req_i.b;
      ALU_SUB: result = req_i.a - req_i.b;
      ALU_AND: result = req_i.a & req_i.b;
      ALU_OR:  result = req_i.a | req_i.b;
      ALU_XOR: result = req_i.a ^ req_i.b;
      ALU_BEQ: cond = (req_i.a == req_i.b);
      ALU_BNE: cond = (req_i.a != req_i.b);
      default: ;
    endcase
  end

  // Branches carry wr_en low and never write back
  assign wb_o = '{
    valid: req_i.valid && req_i.wr_en,
    rd:    req_i.rd,
    data:  result
  };

  assign branch_taken_o  = req_i.valid && cond;
  assign branch_target_o = req_i.pc + req_i.br_offset;

endmodule

`default_nettype wire

//--- hw/hazard_unit.sv
`default_nettype none

module hazard_unit #(
  parameter int MUL_STAGES = core_pkg::MUL_STAGES_DEFAULT
) (
  input  core_pkg::hazard_regs_t         hazard_i,
  input  logic                           dec_valid_i,
  input  core_pkg::wb_t                  alu_busy_i,
  input  core_pkg::wb_t [MUL_STAGES-1:0] mul_tags_i,
  input  core_pkg::wb_t                  wb_busy_i,
  input  logic                           branch_taken_i,
  input  logic                           alu_hold_i,
  output logic                           stall_o,
  output logic                           flush_o
);
  import core_pkg::*;

  logic raw_hit;
  logic waw_hit;

  function automatic logic reg_match(input reg_idx_t idx, input logic used, input wb_t dst);
    return used && (idx != '0) && dst.valid && (dst.rd == idx);
  endfunction

  function automatic logic src_match(input hazard_regs_t src, input wb_t dst);
    return reg_match(src.rs1, src.uses_rs1, dst) || reg_match(src.rs2, src.uses_rs2, dst);
  endfunction

  always_comb begin
    raw_hit = src_match(hazard_i, alu_busy_i) || src_match(hazard_i, wb_busy_i);
    waw_hit = 1'b0;
    for (int i = 0; i < MUL_STAGES; i++) begin
      raw_hit = raw_hit || src_match(hazard_i, mul_tags_i[i]);
      // ALU result must not overtake an older multiply to the same rd
      waw_hit = waw_hit || reg_match(hazard_i.rd, !hazard_i.is_mul, mul_tags_i[i]);
    end
  end

  assign stall_o = alu_hold_i || (dec_valid_i && (raw_hit || waw_hit));
  assign flush_o = branch_taken_i;

endmodule

`default_nettype wire

//--- hw/decoder.sv
`default_nettype none

module decoder (
  input  logic                   valid_i,
  input  core_pkg::addr_t        pc_i,
  input  core_pkg::word_t        instr_i,
  input  core_pkg::word_t        rs1_data_i,
  input  core_pkg::word_t        rs2_data_i,
  output core_pkg::reg_idx_t     rs1_idx_o,
  output core_pkg::reg_idx_t     rs2_idx_o,
  output core_pkg::hazard_regs_t hazard_o,
  output core_pkg::alu_req_t     alu_req_o,
  output core_pkg::mul_req_t     mul_req_o
);
  import core_pkg::*;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;
  localparam logic [6:0] F7_MUL  = 7'b0000001;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_idx_t   rd;
  word_t      imm_i;
  word_t      imm_b;
  logic       legal;

  assign opcode    = opcode_e'(instr_i[6:0]);
  assign rd        = instr_i[11:7];
  assign funct3    = instr_i[14:12];
  assign funct7    = instr_i[31:25];
  assign rs1_idx_o = instr_i[19:15];
  assign rs2_idx_o = instr_i[24:20];

  // Sign-extended immediates
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

  always_comb begin
    legal     = 1'b0;
    alu_req_o = '0;
    mul_req_o = '0;
    hazard_o  = '0;

    alu_req_o.op        = ALU_ADD;
    alu_req_o.rd        = rd;
    alu_req_o.a         = rs1_data_i;
    alu_req_o.b         = rs2_data_i;
    alu_req_o.pc        = pc_i;
    alu_req_o.br_offset = imm_b;
    mul_req_o.rd        = rd;
    mul_req_o.a         = rs1_data_i;
    mul_req_o.b         = rs2_data_i;
    hazard_o.rs1        = rs1_idx_o;
    hazard_o.rs2        = rs2_idx_o;

    case (opcode)
      OPC_OP: begin
        legal             = 1'b1;
        hazard_o.uses_rs1 = 1'b1;
        hazard_o.uses_rs2 = 1'b1;
        hazard_o.rd       = rd;
        if (funct7 == F7_MUL && funct3 == 3'b000) begin
          hazard_o.is_mul = 1'b1;
        end else begin
          case ({funct7, funct3})
            {F7_BASE, 3'b000}: alu_req_o.op = ALU_ADD;
            {F7_ALT,  3'b000}: alu_req_o.op = ALU_SUB;
            {F7_BASE, 3'b100}: alu_req_o.op = ALU_XOR;
            {F7_BASE, 3'b110}: alu_req_o.op = ALU_OR;
            {F7_BASE, 3'b111}: alu_req_o.op = ALU_AND;
            default:           legal = 1'b0;
          endcase
        end
      end
      OPC_OP_IMM: begin
        legal             = (funct3 == 3'b000);
        alu_req_o.b       = imm_i;
        hazard_o.uses_rs1 = 1'b1;
        hazard_o.rd       = rd;
      end
      OPC_BRANCH: begin
        legal             = (funct3 == 3'b000) || (funct3 == 3'b001);
        alu_req_o.op      = (funct3 == 3'b000) ? ALU_BEQ : ALU_BNE;
        hazard_o.uses_rs1 = 1'b1;
        hazard_o.uses_rs2 = 1'b1;
      end
      default: ;
    endcase

    // Anything unknown leaves as a bubble
    if (!legal) begin
      hazard_o.uses_rs1 = 1'b0;
      hazard_o.uses_rs2 = 1'b0;
      hazard_o.rd       = '0;
      hazard_o.is_mul   = 1'b0;
    end

    alu_req_o.wr_en = (hazard_o.rd != '0);
    alu_req_o.valid = valid_i && legal && !hazard_o.is_mul;
    mul_req_o.valid = valid_i && legal && hazard_o.is_mul && (rd != '0);
  end

endmodule

`default_nettype wire

//--- hw/fetch_unit.sv
`default_nettype none

module fetch_unit (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            stall_i,
  input  logic            branch_taken_i,
  input  core_pkg::addr_t branch_target_i,
  input  core_pkg::word_t imem_data_i,
  output core_pkg::addr_t imem_addr_o,
  output logic            dec_valid_o,
  output core_pkg::addr_t dec_pc_o,
  output core_pkg::word_t dec_instr_o
);
  import core_pkg::*;

  addr_t pc_q;
  logic  valid_q;
  addr_t dec_pc_q;
  word_t dec_instr_q;

  assign imem_addr_o = pc_q;

  // Redirect wins over a stall
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pc_q    <= RESET_PC;
      valid_q <= 1'b0;
    end else if (branch_taken_i) begin
      pc_q    <= branch_target_i;
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      pc_q    <= pc_q + 32'd4;
      valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      dec_pc_q    <= pc_q;
      dec_instr_q <= imem_data_i;
    end
  end

  assign dec_valid_o = valid_q;
  assign dec_pc_o    = dec_pc_q;
  assign dec_instr_o = dec_instr_q;

endmodule

`default_nettype wire

//--- hw/core_pkg.sv
`default_nettype none

package core_pkg;

  // ==============================
  // Widths and base types
  // ==============================
  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [XLEN-1:0]      addr_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_BEQ,
    ALU_BNE
  } alu_op_e;

  // Owner of the commit slot
  typedef enum logic {
    WB_SRC_ALU,
    WB_SRC_MUL
  } wb_src_e;

  // ==============================
  // Pipeline payloads
  // ==============================
  typedef struct packed {
    logic     valid;
    alu_op_e  op;
    reg_idx_t rd;
    logic     wr_en;
    word_t    a;
    word_t    b;
    addr_t    pc;
    word_t    br_offset;
  } alu_req_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    a;
    word_t    b;
  } mul_req_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    data;
  } wb_t;

  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    // Destination, x0 when nothing is written
    reg_idx_t rd;
    logic     uses_rs1;
    logic     uses_rs2;
    logic     is_mul;
  } hazard_regs_t;

  // addi x0, x0, 0
  localparam word_t NOP_INSTR          = 32'h0000_0013;
  localparam addr_t RESET_PC           = '0;
  localparam int    MUL_STAGES_DEFAULT = 3;

endpackage

`default_nettype wire
